// File: project.f
source/scope_types_pkg.sv
source/acq_ctl_pkg.sv
source/scope_str_if.sv
source/scope_dec_avg.sv
source/scope_edge_trg.sv
source/scope_acq_ctl.sv
source/scope_top.sv
verif/tb_scope_top.sv

// File: run_sim.sh
#!/bin/sh
# build the scope testbench with Verilator and run it
# exits nonzero when the run log reports a failure
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_scope_top \
  -f project.f -o sim_scope > build.log 2>&1 \
  && ./obj_dir/sim_scope > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

// File: source/acq_ctl_pkg.sv
////////////////////////////////////////
// acquisition controller definitions
// command opcodes and FSM states
////////////////////////////////////////

package acq_ctl_pkg;

  // post-trigger counter width
  parameter int unsigned DWP_DEF = 16;

  // commands from the host side
  typedef enum logic [1:0] {
    CMD_NOP  = 2'd0,  // no action
    CMD_ARM  = 2'd1,  // wait for trigger
    CMD_STOP = 2'd2   // abort to idle
  } acq_cmd_t;

  // controller FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // dropping samples
    ST_ARMED = 2'd1,  // waiting for a tagged sample
    ST_POST  = 2'd2,  // passing post-trigger samples
    ST_DONE  = 2'd3   // capture complete
  } acq_state_t;

endpackage : acq_ctl_pkg

// File: source/scope_acq_ctl.sv
////////////////////////////////////////
// acquisition controller
// armed by command, passes cfg_pst+1
// samples after the trigger sample
////////////////////////////////////////

module scope_acq_ctl #(
  int unsigned DW  = scope_types_pkg::DWO_DEF,  // sample width
  int unsigned DWP = acq_ctl_pkg::DWP_DEF       // post counter width
)(
  input  logic                  clk,
  input  logic                  rstn,
  input  acq_ctl_pkg::acq_cmd_t cmd,
  input  logic        [DWP-1:0] cfg_pst,  // post samples minus one
  scope_str_if.snk              sti,
  output logic signed [DW-1:0]  acq_dat,
  output logic                  acq_vld,
  input  logic                  acq_rdy,
  output logic                  trg_out,   // trigger pulse
  output logic                  acq_done   // capture finished
);

  acq_ctl_pkg::acq_state_t state;
  logic [DWP-1:0]          pst_cnt;  // output transfers in POST
  logic                    in_post;
  logic                    sti_trn;
  logic                    acq_trn;
  logic                    pst_end;

  ////////////////////////////////////////
  // datapath and status
  ////////////////////////////////////////

  assign in_post = (state == acq_ctl_pkg::ST_POST);

  assign acq_dat = sti.dat;
  assign acq_vld = in_post & sti.vld;
  assign sti.rdy = in_post ? acq_rdy : 1'b1;  // drop outside POST

  assign sti_trn = sti.vld & sti.rdy;
  assign acq_trn = acq_vld & acq_rdy;
  assign pst_end = (pst_cnt == cfg_pst);

  // trigger sample itself is discarded
  assign trg_out  = (state == acq_ctl_pkg::ST_ARMED) & sti_trn & sti.trg;
  assign acq_done = (state == acq_ctl_pkg::ST_DONE);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= acq_ctl_pkg::ST_IDLE;
      pst_cnt <= '0;
    end else if (cmd == acq_ctl_pkg::CMD_STOP) begin
      state <= acq_ctl_pkg::ST_IDLE;  // abort from anywhere
    end else begin
      case (state)
        acq_ctl_pkg::ST_IDLE,
        acq_ctl_pkg::ST_DONE: begin
          if (cmd == acq_ctl_pkg::CMD_ARM) state <= acq_ctl_pkg::ST_ARMED;
        end
        acq_ctl_pkg::ST_ARMED: begin
          if (trg_out) begin
            state   <= acq_ctl_pkg::ST_POST;
            pst_cnt <= '0;
          end
        end
        acq_ctl_pkg::ST_POST: begin
          if (acq_trn) begin
            if (pst_end) state   <= acq_ctl_pkg::ST_DONE;
            else         pst_cnt <= pst_cnt + 1'b1;
          end
        end
        default: state <= acq_ctl_pkg::ST_IDLE;
      endcase
    end
  end

  ap_trg_pulse: assert property (@(posedge clk) disable iff (!rstn)
    trg_out |=> !trg_out);

  // stalled capture sample stays valid and unchanged in POST
  ap_vld_hold: assert property (@(posedge clk) disable iff (!rstn)
    acq_vld && !acq_rdy && (cmd != acq_ctl_pkg::CMD_STOP) |=> acq_vld && $stable(acq_dat));

endmodule : scope_acq_ctl

// File: source/scope_dec_avg.sv
////////////////////////////////////////
// decimator with optional averaging
// reduces the adc stream by cfg_dec+1
// sum is shifted right by cfg_shr
////////////////////////////////////////

module scope_dec_avg #(
  int unsigned DWI = scope_types_pkg::DWI_DEF,  // input width
  int unsigned DWO = scope_types_pkg::DWO_DEF,  // output width
  int unsigned DWC = scope_types_pkg::DWC_DEF,  // group counter width
  int unsigned DWS = scope_types_pkg::DWS_DEF   // shift width
)(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  ctl_clr,  // restart group
  input  logic                  cfg_avg,  // 1 = sum and shift
  input  logic        [DWC-1:0] cfg_dec,  // group size minus one
  input  logic        [DWS-1:0] cfg_shr,  // right shift of sum
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  scope_str_if.src              sto
);

  logic signed [DWC+DWI-1:0] sum;      // running group sum
  logic signed [DWC+DWI-1:0] sum_nxt;  // sum incl. current sample
  logic signed [DWC+DWI-1:0] sum_shr;  // scaled group sum
  logic        [DWC-1:0]     cnt;      // samples seen in group
  logic                      sti_trn;
  logic                      grp_end;  // current sample closes group
  logic                      grp_ld;   // load output register

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  assign sti_rdy = sto.rdy | ~sto.vld;  // free slot or draining
  assign sti_trn = sti_vld & sti_rdy;

  assign grp_end = (cnt == cfg_dec);
  assign grp_ld  = sti_trn & grp_end & ~ctl_clr;

  assign sum_nxt = sum + sti_dat;  // sign extended add
  assign sum_shr = sum_nxt >>> cfg_shr;

  assign sto.trg = 1'b0;  // no trigger info at this stage

  ////////////////////////////////////////
  // group counter and accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt     <= '0;
      sum     <= '0;
      sto.vld <= 1'b0;
    end else begin
      if (ctl_clr) begin
        cnt <= '0;  // pending output stays
        sum <= '0;
      end else if (sti_trn) begin
        if (grp_end) begin
          cnt <= '0;
          sum <= '0;  // next sample starts a fresh sum
        end else begin
          cnt <= cnt + 1'b1;
          sum <= sum_nxt;
        end
      end
      // output valid
      if (grp_ld) begin
        sto.vld <= 1'b1;
      end else if (sto.rdy) begin
        sto.vld <= 1'b0;
      end
    end
  end

  // output sample, low DWO bits only
  always_ff @(posedge clk) begin
    if (grp_ld) begin
      sto.dat <= cfg_avg ? sum_shr[DWO-1:0] : DWO'(sti_dat);
    end
  end

  // a waiting sample must stay put until taken
  ap_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto.vld && !sto.rdy |=> sto.vld && $stable(sto.dat));

endmodule : scope_dec_avg

// File: source/scope_edge_trg.sv
////////////////////////////////////////
// edge trigger stage
// level crossing with hysteresis or an
// external pulse tags the sample stream
////////////////////////////////////////

module scope_edge_trg #(
  int unsigned DW = scope_types_pkg::DWO_DEF  // sample width
)(
  input  logic                      clk,
  input  logic                      rstn,
  input  scope_types_pkg::trg_src_t cfg_src,  // trigger source
  input  logic signed [DW-1:0]      cfg_lvl,  // trigger level
  input  logic        [DW-1:0]      cfg_hys,  // hysteresis band
  input  logic                      trg_ext,  // external pulse
  scope_str_if.snk                  sti,
  scope_str_if.src                  sto
);

  logic signed [DW+1:0] dat_ext;  // two guard bits vs overflow
  logic signed [DW+1:0] lvl_ext;
  logic signed [DW+1:0] hys_ext;
  logic signed [DW+1:0] thr_lo;   // rising arm threshold
  logic signed [DW+1:0] thr_hi;   // falling arm threshold
  logic                 sti_trn;
  logic                 hys_arm;  // band left on the far side
  logic                 hys_set;  // current sample arms
  logic                 ext_pnd;  // latched external pulse
  logic                 tag;      // current sample is trigger

  assign sti.rdy = sto.rdy | ~sto.vld;
  assign sti_trn = sti.vld & sti.rdy;

  assign dat_ext = sti.dat;
  assign lvl_ext = cfg_lvl;
  assign hys_ext = {2'b00, cfg_hys};  // band is unsigned
  assign thr_lo  = lvl_ext - hys_ext;
  assign thr_hi  = lvl_ext + hys_ext;

  ////////////////////////////////////////
  // trigger decision
  ////////////////////////////////////////

  always_comb begin
    hys_set = 1'b0;
    tag     = 1'b0;
    case (cfg_src)
      scope_types_pkg::TRG_POS: begin
        hys_set = (dat_ext <= thr_lo);
        tag     = hys_arm && (dat_ext >= lvl_ext);
      end
      scope_types_pkg::TRG_NEG: begin
        hys_set = (dat_ext >= thr_hi);
        tag     = hys_arm && (dat_ext <= lvl_ext);
      end
      scope_types_pkg::TRG_EXT: tag = ext_pnd;
      default:                  tag = 1'b0;  // TRG_NONE
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      hys_arm <= 1'b0;
      ext_pnd <= 1'b0;
    end else begin
      if ((cfg_src == scope_types_pkg::TRG_POS) || (cfg_src == scope_types_pkg::TRG_NEG)) begin
        if (sti_trn && tag) begin
          hys_arm <= 1'b0;  // one trigger per arm
        end else if (sti_trn && hys_set) begin
          hys_arm <= 1'b1;
        end
      end else begin
        hys_arm <= 1'b0;
      end
      // external pulse waits for the next sample
      if (cfg_src != scope_types_pkg::TRG_EXT) ext_pnd <= 1'b0;
      else if (trg_ext)                        ext_pnd <= 1'b1;
      else if (sti_trn)                        ext_pnd <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto.vld <= 1'b0;
      sto.trg <= 1'b0;
    end else if (sti_trn) begin
      sto.vld <= 1'b1;
      sto.trg <= tag | sti.trg;  // keep upstream tags
    end else if (sto.rdy) begin
      sto.vld <= 1'b0;
      sto.trg <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trn) sto.dat <= sti.dat;
  end

  ap_trg_vld: assert property (@(posedge clk) disable iff (!rstn)
    sto.trg |-> sto.vld);

endmodule : scope_edge_trg

// File: source/scope_str_if.sv
////////////////////////////////////////
// sample stream between scope stages
// valid/ready handshake plus trigger tag
////////////////////////////////////////

interface scope_str_if #(
  int unsigned DW = scope_types_pkg::DWO_DEF  // sample width
);

  logic signed [DW-1:0] dat;  // sample
  logic                 vld;  // sample valid
  logic                 rdy;  // sink can accept
  logic                 trg;  // sample is a trigger point

  // producing side
  modport src (
    output dat, vld, trg,
    input  rdy
  );

  // consuming side
  modport snk (
    input  dat, vld, trg,
    output rdy
  );

endinterface : scope_str_if

// File: source/scope_top.sv
////////////////////////////////////////
// scope acquisition path top level
// decimator -> edge trigger -> capture
// configuration arrives on plain ports
////////////////////////////////////////

module scope_top #(
  int unsigned DWI = scope_types_pkg::DWI_DEF,
  int unsigned DWO = scope_types_pkg::DWO_DEF,
  int unsigned DWC = scope_types_pkg::DWC_DEF,
  int unsigned DWS = scope_types_pkg::DWS_DEF,
  int unsigned DWP = acq_ctl_pkg::DWP_DEF
)(
  input  logic                      clk,
  input  logic                      rstn,
  // adc stream in
  input  logic signed [DWI-1:0]     adc_dat,
  input  logic                      adc_vld,
  output logic                      adc_rdy,
  // captured stream out
  output logic signed [DWO-1:0]     acq_dat,
  output logic                      acq_vld,
  input  logic                      acq_rdy,
  // control and configuration
  input  logic                      ctl_clr,
  input  acq_ctl_pkg::acq_cmd_t     cmd,
  input  logic                      cfg_avg,
  input  logic        [DWC-1:0]     cfg_dec,
  input  logic        [DWS-1:0]     cfg_shr,
  input  scope_types_pkg::trg_src_t cfg_src,
  input  logic signed [DWO-1:0]     cfg_lvl,
  input  logic        [DWO-1:0]     cfg_hys,
  input  logic        [DWP-1:0]     cfg_pst,
  input  logic                      trg_ext,
  // status
  output logic                      trg_out,
  output logic                      acq_done
);

  scope_str_if #(.DW(DWO)) str_dec ();  // reduced stream
  scope_str_if #(.DW(DWO)) str_trg ();  // tagged stream

  scope_dec_avg #(.DWI(DWI), .DWO(DWO), .DWC(DWC), .DWS(DWS)) u_dec (
    .clk(clk), .rstn(rstn),
    .ctl_clr(ctl_clr),
    .cfg_avg(cfg_avg), .cfg_dec(cfg_dec), .cfg_shr(cfg_shr),
    .sti_dat(adc_dat), .sti_vld(adc_vld), .sti_rdy(adc_rdy),
    .sto(str_dec)
  );

  scope_edge_trg #(.DW(DWO)) u_trg (
    .clk(clk), .rstn(rstn),
    .cfg_src(cfg_src), .cfg_lvl(cfg_lvl), .cfg_hys(cfg_hys),
    .trg_ext(trg_ext),
    .sti(str_dec), .sto(str_trg)
  );

  scope_acq_ctl #(.DW(DWO), .DWP(DWP)) u_acq (
    .clk(clk), .rstn(rstn),
    .cmd(cmd), .cfg_pst(cfg_pst),
    .sti(str_trg),
    .acq_dat(acq_dat), .acq_vld(acq_vld), .acq_rdy(acq_rdy),
    .trg_out(trg_out), .acq_done(acq_done)
  );

endmodule : scope_top

// File: source/scope_types_pkg.sv
////////////////////////////////////////
// stream widths and trigger source codes
// shared by the acquisition datapath
// referenced by scoped name only
////////////////////////////////////////

package scope_types_pkg;

  ////////////////////////////////////////
  // stream widths
  ////////////////////////////////////////

  parameter int unsigned DWI_DEF = 14;  // adc sample width
  parameter int unsigned DWO_DEF = 14;  // reduced stream width

  // decimation
  parameter int unsigned DWC_DEF = 17;  // group counter width
  parameter int unsigned DWS_DEF = 4;   // shift amount width

  ////////////////////////////////////////
  // trigger source select
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    TRG_NONE = 2'd0,  // trigger disabled
    TRG_POS  = 2'd1,  // rising level crossing
    TRG_NEG  = 2'd2,  // falling level crossing
    TRG_EXT  = 2'd3   // external pulse
  } trg_src_t;

endpackage : scope_types_pkg

// File: verif/scope_cases.txt
# avg dec shr src lvl hys pst wave start step span count bp ext stop
# src 0 none 1 pos 2 neg 3 ext; wave 0 up 1 down 2 triangle; stop 0 runs to done
0 3 0 3    0   0  5 0 -100   7  0  48 0 2 0
1 7 3 1    0  50  4 0 -500  13  0  96 0 0 0
0 1 0 1  200 100  7 2 -300  20 40 160 0 0 0
1 3 2 2 -100  80  6 2  400 -15 50 200 0 0 0
0 0 0 1  100 200  3 2   50  10  8  64 0 0 0
0 2 0 3    0   0  9 1 3000  11  0  90 0 4 0
0 1 0 1  200 100  7 2 -300  20 40 160 1 0 0
1 7 3 2    0  50  4 1  500  13  0  96 1 0 0
1 4 1 3    0   0  8 0 7000   9  0 100 1 3 0
0 1 0 1    0  10 20 0 -200   5  0 200 0 0 5

// File: verif/tb_scope_top.sv
////////////////////////////////////////
// self-checking testbench for scope_top
// reads cases, streams adc samples and
// checks the capture against a rule model
////////////////////////////////////////

module tb_scope_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DWI = scope_types_pkg::DWI_DEF;
  localparam int DWO = scope_types_pkg::DWO_DEF;
  localparam int DWC = scope_types_pkg::DWC_DEF;
  localparam int DWS = scope_types_pkg::DWS_DEF;
  localparam int DWP = acq_ctl_pkg::DWP_DEF;

  // one line of the case file
  typedef struct packed {
    int avg;
    int dec;
    int shr;
    int src;
    int lvl;
    int hys;
    int pst;
    int wav;    // 0 up, 1 down, 2 triangle
    int start;
    int step;
    int span;   // triangle half period
    int cnt;    // adc samples
    int bp;     // random gaps on both ports
    int ext;    // reduced index of the ext trigger
    int stop;   // stop after this many captured
  } case_t;

  logic                      clk;
  logic                      rstn;
  logic signed [DWI-1:0]     adc_dat;
  logic                      adc_vld;
  logic                      adc_rdy;
  logic signed [DWO-1:0]     acq_dat;
  logic                      acq_vld;
  logic                      acq_rdy;
  logic                      ctl_clr;
  acq_ctl_pkg::acq_cmd_t     cmd;
  logic                      cfg_avg;
  logic        [DWC-1:0]     cfg_dec;
  logic        [DWS-1:0]     cfg_shr;
  scope_types_pkg::trg_src_t cfg_src;
  logic signed [DWO-1:0]     cfg_lvl;
  logic        [DWO-1:0]     cfg_hys;
  logic        [DWP-1:0]     cfg_pst;
  logic                      trg_ext;
  logic                      trg_out;
  logic                      acq_done;

  case_t                   cases[$];
  int                      red_q[$];  // reduced stream
  int                      exp_q[$];  // expected capture
  int                      exp_trg;   // expected trg_out pulses
  bit                      exp_done;
  acq_ctl_pkg::acq_state_t exp_st;    // for messages only
  logic [31:0]             rng;
  int                      err_val;
  int                      err_oth;
  int                      wd_cyc;    // watchdog budget
  bit                      loaded;

  scope_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // watchdog, 20 cycles per adc sample
  initial begin
    wait (loaded);
    repeat (wd_cyc) @(posedge clk);
    $display("timeout: run did not finish within %0d clock cycles", wd_cyc);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // adc sample i of a case waveform
  function automatic int wave_val(input case_t cc, input int i);
    int p;
    if (cc.wav == 0) return cc.start + i * cc.step;
    if (cc.wav == 1) return cc.start - i * cc.step;
    p = i % (2 * cc.span);  // position in triangle period
    if (p < cc.span) return cc.start + p * cc.step;
    return cc.start + (2 * cc.span - p) * cc.step;
  endfunction

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    case_t cc;
    fd = $fopen("verif/scope_cases.txt", "r");
    if (fd == 0) begin
      err_oth++;
      $display("cannot open the case file verif/scope_cases.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#") begin  // skip comments, blanks
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                      cc.avg, cc.dec, cc.shr, cc.src, cc.lvl, cc.hys, cc.pst, cc.wav,
                      cc.start, cc.step, cc.span, cc.cnt, cc.bp, cc.ext, cc.stop);
          if (n == 15) cases.push_back(cc);
          else begin
            err_oth++;
            $display("malformed line in case file: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  task automatic build_model(input case_t cc);
    longint         sum;
    logic [DWO-1:0] b;
    int             v;
    int             i;
    int             t;
    int             avail;
    bit             arm;
    red_q.delete();
    exp_q.delete();
    sum = 0;
    for (i = 0; i < cc.cnt; i++) begin
      v = wave_val(cc, i);
      sum += v;
      if (i % (cc.dec + 1) == cc.dec) begin  // group closes
        b = (cc.avg != 0) ? DWO'(sum >>> cc.shr) : DWO'(v);  // low bits kept
        red_q.push_back(int'($signed(b)));
        sum = 0;
      end
    end
    t   = -1;  // trigger index in reduced stream
    arm = 1'b0;
    for (i = 0; i < red_q.size() && t < 0; i++) begin
      case (scope_types_pkg::trg_src_t'(cc.src))
        scope_types_pkg::TRG_POS: begin
          if (arm && red_q[i] >= cc.lvl) t = i;
          else if (red_q[i] <= cc.lvl - cc.hys) arm = 1'b1;  // left band below
        end
        scope_types_pkg::TRG_NEG: begin
          if (arm && red_q[i] <= cc.lvl) t = i;
          else if (red_q[i] >= cc.lvl + cc.hys) arm = 1'b1;
        end
        scope_types_pkg::TRG_EXT: if (i == cc.ext) t = i;
        default: arm = 1'b0;  // never triggers
      endcase
    end
    avail = (t < 0) ? 0 : red_q.size() - t - 1;  // trigger sample dropped
    for (i = 0; i < avail && i <= cc.pst; i++) exp_q.push_back(red_q[t + 1 + i]);
    while (cc.stop > 0 && exp_q.size() > cc.stop) exp_q.pop_back();
    exp_trg  = (t >= 0) ? 1 : 0;
    exp_done = (t >= 0) && (avail > cc.pst) && (cc.stop == 0);
    if (t < 0)            exp_st = acq_ctl_pkg::ST_ARMED;
    else if (cc.stop > 0) exp_st = acq_ctl_pkg::ST_IDLE;
    else if (exp_done)    exp_st = acq_ctl_pkg::ST_DONE;
    else                  exp_st = acq_ctl_pkg::ST_POST;
  endtask

  ////////////////////////////////////////
  // one case: setup, stream, check
  ////////////////////////////////////////

  task automatic run_case(input int c);
    case_t cc;
    int    sent;
    int    got;
    int    trg_cnt;
    int    idle;
    int    pcnt;
    bit    xfer;
    bit    ext_done;
    bit    stop_sent;
    bit    stopped;
    cc = cases[c];
    build_model(cc);
    @(negedge clk);
    cfg_src = scope_types_pkg::TRG_NONE;  // clears arm flag and ext latch
    ctl_clr = 1'b1;
    cmd     = acq_ctl_pkg::CMD_STOP;
    adc_vld = 1'b0;
    acq_rdy = 1'b1;
    trg_ext = 1'b0;
    @(negedge clk);
    ctl_clr = 1'b0;
    cmd     = acq_ctl_pkg::CMD_ARM;
    cfg_avg = (cc.avg != 0);
    cfg_dec = DWC'(cc.dec);
    cfg_shr = DWS'(cc.shr);
    cfg_src = scope_types_pkg::trg_src_t'(cc.src);
    cfg_lvl = DWO'(cc.lvl);
    cfg_hys = DWO'(cc.hys);
    cfg_pst = DWP'(cc.pst);
    $display("case %0d: %s, %0d reduced, %0d to capture, ends in %s", c,
             cfg_src.name(), red_q.size(), exp_q.size(), exp_st.name());
    sent      = 0;
    got       = 0;
    trg_cnt   = 0;
    idle      = 0;
    pcnt      = 0;
    xfer      = 1'b0;
    ext_done  = 1'b0;
    stop_sent = 1'b0;
    stopped   = 1'b0;
    while (sent < cc.cnt || idle < 16) begin
      @(negedge clk);
      cmd     = acq_ctl_pkg::CMD_NOP;
      trg_ext = 1'b0;
      if (xfer) adc_vld = 1'b0;  // held until taken
      if (!adc_vld && sent < cc.cnt) begin
        if (cfg_src == scope_types_pkg::TRG_EXT && !ext_done &&
            sent == cc.ext * (cc.dec + 1)) begin
          pcnt++;  // pause so the pipeline drains
          trg_ext  = (pcnt == 6);
          ext_done = (pcnt == 7);
        end else begin
          rng     = xorshift(rng);
          adc_vld = (cc.bp == 0) || (rng[1:0] != 2'b00);
          adc_dat = DWI'(wave_val(cc, sent));
        end
      end
      rng     = xorshift(rng);
      acq_rdy = (cc.bp == 0) || (rng[1:0] != 2'b00);
      if (cc.stop > 0 && got == cc.stop && !stop_sent) begin
        cmd       = acq_ctl_pkg::CMD_STOP;
        acq_rdy   = 1'b0;  // nothing moves in the stop cycle
        stop_sent = 1'b1;
      end
      #10;  // sample mid low phase
      xfer = adc_vld && adc_rdy;
      if (xfer) begin
        sent++;
        idle = 0;
      end
      if (trg_out) trg_cnt++;
      if (stopped && (acq_vld || acq_done)) begin
        err_oth++;
        $display("case %0d: acq_vld or acq_done went high after the stop command", c);
      end
      if (acq_vld && acq_rdy) begin
        idle = 0;
        if (got >= exp_q.size()) begin
          err_oth++;
          $display("case %0d: extra output sample %0d beyond the capture", c, got);
        end else if (int'(acq_dat) != exp_q[got]) begin
          err_val++;
          $display("[FAIL] %0d ns acq_dat exp=%0d got=%0d (case %0d, sample %0d)",
                   $time, exp_q[got], int'(acq_dat), c, got);
        end
        got++;
      end else if (!xfer) begin
        idle++;
      end
      if (stop_sent) stopped = 1'b1;
    end
    if (got != exp_q.size()) begin
      err_oth++;
      $display("case %0d: captured %0d samples, expected %0d", c, got, exp_q.size());
    end
    if (trg_cnt != exp_trg) begin
      err_val++;
      $display("[FAIL] %0d ns trg_out pulses exp=%0d got=%0d", $time, exp_trg, trg_cnt);
    end
    if (acq_done != exp_done) begin
      err_val++;
      $display("[FAIL] %0d ns acq_done exp=%0b got=%0b", $time, exp_done, acq_done);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int c;
    int total;
    rstn    = 1'b0;
    adc_dat = '0;
    adc_vld = 1'b0;
    acq_rdy = 1'b1;
    ctl_clr = 1'b0;
    cmd     = acq_ctl_pkg::CMD_NOP;
    cfg_avg = 1'b0;
    cfg_dec = '0;
    cfg_shr = '0;
    cfg_src = scope_types_pkg::TRG_NONE;
    cfg_lvl = '0;
    cfg_hys = '0;
    cfg_pst = '0;
    trg_ext = 1'b0;
    rng     = 32'h7167;
    err_val = 0;
    err_oth = 0;
    load_cases();
    if (cases.size() == 0) begin
      err_oth++;
      $display("no usable cases in the case file");
    end
    total = 0;
    for (c = 0; c < cases.size(); c++) total += cases[c].cnt;
    wd_cyc = total * 20 + 16;
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    #10;
    if (acq_vld || trg_out || acq_done || !adc_rdy) begin
      err_oth++;
      $display("outputs not idle after reset");
    end
    for (c = 0; c < cases.size(); c++) run_case(c);
    $display("summary: %0d value errors, %0d other errors, %0d cases",
             err_val, err_oth, cases.size());
    if (err_val == 0 && err_oth == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_scope_top
